/* sources.f */
src/uart_bridge_pkg.sv
src/cmd_dispatch.sv
src/uart_frame_tx.sv
src/uart_frame_rx.sv
src/uart_cmd_channel.sv
src/read_collector.sv
src/uart_cmd_bridge.sv
test/tb_clock_gen.sv
test/uart_device_model.sv
test/tb_uart_cmd_bridge.sv

/* src/cmd_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_dispatch (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     cmd_req,
  output logic                                     cmd_ack,
  input  uart_bridge_pkg::chan_t                   cmd_chan,
  input  uart_bridge_pkg::cmd_t                    cmd_word,
  output logic [uart_bridge_pkg::NUM_CHANNELS-1:0] go_req,
  input  logic [uart_bridge_pkg::NUM_CHANNELS-1:0] go_ack,
  output uart_bridge_pkg::cmd_t                    go_word
);

  import uart_bridge_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_GO, S_GO_DROP, S_ACK} state_t;

  state_t state;
  chan_t  chan_q;

  // only the addressed channel sees a request
  assign go_req  = (state == S_GO) ? (NUM_CHANNELS'(1) << chan_q) : '0;
  assign cmd_ack = (state == S_ACK);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state  <= S_IDLE;
      chan_q <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (cmd_req)
          begin
            chan_q <= cmd_chan;
            state  <= S_GO;
          end
        S_GO:      if (go_ack[chan_q]) state <= S_GO_DROP;   // a busy channel stalls here
        S_GO_DROP: if (!go_ack[chan_q]) state <= S_ACK;
        S_ACK:     if (!cmd_req) state <= S_IDLE;
        default:   state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == S_IDLE && cmd_req)
      go_word <= cmd_word;
  end

endmodule

`default_nettype wire

/* src/read_collector.sv */
`timescale 1ns/1ps
`default_nettype none

module read_collector (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic [uart_bridge_pkg::NUM_CHANNELS-1:0]            rd_req,
  output logic [uart_bridge_pkg::NUM_CHANNELS-1:0]            rd_ack,
  input  uart_bridge_pkg::byte_t [uart_bridge_pkg::NUM_CHANNELS-1:0]   rd_data,
  input  uart_bridge_pkg::status_t [uart_bridge_pkg::NUM_CHANNELS-1:0] rd_status,
  output logic                                                rsp_req,
  input  logic                                                rsp_ack,
  output uart_bridge_pkg::chan_t                              rsp_chan,
  output uart_bridge_pkg::byte_t                              rsp_data,
  output uart_bridge_pkg::status_t                            rsp_status
);

  import uart_bridge_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_ACK_CH, S_RSP, S_RSP_DROP} state_t;

  state_t state;
  chan_t  pick;
  logic   pick_vld;

  // nearest requester after the last served channel wins
  always_comb
  begin
    int idx;
    pick_vld = 1'b0;
    pick     = rsp_chan;
    for (int k = NUM_CHANNELS; k > 0; k--)
    begin
      idx = (int'(rsp_chan) + k) % NUM_CHANNELS;
      if (rd_req[idx])
      begin
        pick_vld = 1'b1;
        pick     = chan_t'(idx);
      end
    end
  end

  assign rd_ack  = (state == S_ACK_CH) ? (NUM_CHANNELS'(1) << rsp_chan) : '0;
  assign rsp_req = (state == S_RSP);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      rsp_chan <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
          if (pick_vld)
          begin
            rsp_chan <= pick;
            state    <= S_ACK_CH;
          end
        S_ACK_CH:   if (!rd_req[rsp_chan]) state <= S_RSP;
        S_RSP:      if (rsp_ack) state <= S_RSP_DROP;
        S_RSP_DROP: if (!rsp_ack) state <= S_IDLE;
        default:    state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == S_IDLE && pick_vld)
    begin
      rsp_data   <= rd_data[pick];
      rsp_status <= rd_status[pick];
    end
  end

endmodule

`default_nettype wire

/* src/uart_bridge_pkg.sv */
`default_nettype none

package uart_bridge_pkg;

  localparam int NUM_CHANNELS      = 4;
  localparam int BIT_CYCLES        = 16;  // simulation baud, raise for a real board
  localparam int GAP_BITS          = 4;
  localparam int RESP_TIMEOUT_BITS = 32;

  // start, eight data, parity, stop
  localparam int FRAME_BITS     = 11;
  localparam int GAP_CYCLES     = GAP_BITS * BIT_CYCLES;
  localparam int TIMEOUT_CYCLES = RESP_TIMEOUT_BITS * BIT_CYCLES;
  localparam int CNT_W          = $clog2(TIMEOUT_CYCLES + 1);

  typedef logic [1:0]       chan_t;
  typedef logic [15:0]      cmd_t;   // [15] write, [14:8] address, [7:0] data
  typedef logic [7:0]       byte_t;
  typedef logic [1:0]       status_t;
  typedef logic [CNT_W-1:0] bit_cnt_t;

  localparam status_t STATUS_OK         = 2'd0;
  localparam status_t STATUS_PARITY_ERR = 2'd1;
  localparam status_t STATUS_TIMEOUT    = 2'd2;

endpackage

`default_nettype wire

/* src/uart_cmd_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_bridge (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  logic                                     cmd_req,
  output logic                                     cmd_ack,
  input  uart_bridge_pkg::chan_t                   cmd_chan,
  input  uart_bridge_pkg::cmd_t                    cmd_word,
  output logic                                     rsp_req,
  input  logic                                     rsp_ack,
  output uart_bridge_pkg::chan_t                   rsp_chan,
  output uart_bridge_pkg::byte_t                   rsp_data,
  output uart_bridge_pkg::status_t                 rsp_status,
  output logic [uart_bridge_pkg::NUM_CHANNELS-1:0] tx,
  input  logic [uart_bridge_pkg::NUM_CHANNELS-1:0] rx
);

  import uart_bridge_pkg::*;

  wire logic [NUM_CHANNELS-1:0]    go_req;
  wire logic [NUM_CHANNELS-1:0]    go_ack;
  wire cmd_t                       go_word;   // shared, qualified by go_req
  wire logic [NUM_CHANNELS-1:0]    rd_req;
  wire logic [NUM_CHANNELS-1:0]    rd_ack;
  wire byte_t [NUM_CHANNELS-1:0]   rd_data;
  wire status_t [NUM_CHANNELS-1:0] rd_status;

  cmd_dispatch cmd_dispatch_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_req  (cmd_req),
    .cmd_ack  (cmd_ack),
    .cmd_chan (cmd_chan),
    .cmd_word (cmd_word),
    .go_req   (go_req),
    .go_ack   (go_ack),
    .go_word  (go_word)
  );

  for (genvar i = 0; i < NUM_CHANNELS; i++)
  begin : g_chan
    uart_cmd_channel chan_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .go_req    (go_req[i]),
      .go_ack    (go_ack[i]),
      .go_word   (go_word),
      .rd_req    (rd_req[i]),
      .rd_ack    (rd_ack[i]),
      .rd_data   (rd_data[i]),
      .rd_status (rd_status[i]),
      .tx        (tx[i]),
      .rx        (rx[i])
    );
  end

  read_collector read_collector_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_req     (rd_req),
    .rd_ack     (rd_ack),
    .rd_data    (rd_data),
    .rd_status  (rd_status),
    .rsp_req    (rsp_req),
    .rsp_ack    (rsp_ack),
    .rsp_chan   (rsp_chan),
    .rsp_data   (rsp_data),
    .rsp_status (rsp_status)
  );

endmodule

`default_nettype wire

/* src/uart_cmd_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_channel (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     go_req,
  output logic                     go_ack,
  input  uart_bridge_pkg::cmd_t    go_word,
  output logic                     rd_req,
  input  logic                     rd_ack,
  output uart_bridge_pkg::byte_t   rd_data,
  output uart_bridge_pkg::status_t rd_status,
  output logic                     tx,
  input  logic                     rx
);

  import uart_bridge_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE, S_TX_HI, S_GAP, S_TX_LO, S_RD_WAIT, S_RD_OFFER, S_RD_DROP
  } state_t;

  state_t   state;
  cmd_t     word_q;
  bit_cnt_t gap_cnt;
  logic     accept;
  logic     tx_start;
  byte_t    tx_byte;
  logic     tx_done;
  logic     rx_start;
  logic     rx_done;
  byte_t    rx_byte;
  status_t  rx_status;

  assign accept  = (state == S_IDLE) && go_req && !go_ack;
  assign tx_byte = (state == S_TX_LO) ? word_q[7:0] : word_q[15:8];

  uart_frame_tx tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  uart_frame_rx rx_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx_start  (rx_start),
    .rx        (rx),
    .rx_done   (rx_done),
    .rx_byte   (rx_byte),
    .rx_status (rx_status)
  );

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= S_IDLE;
      go_ack   <= 1'b0;
      rd_req   <= 1'b0;
      tx_start <= 1'b0;
      rx_start <= 1'b0;
      gap_cnt  <= '0;
    end
    else
    begin
      tx_start <= accept;
      rx_start <= 1'b0;
      if (accept)
        go_ack <= 1'b1;
      else if (!go_req)
        go_ack <= 1'b0;
      case (state)
        S_IDLE: if (accept) state <= S_TX_HI;
        S_TX_HI:
          if (tx_done && word_q[15])
          begin
            state   <= S_GAP;
            gap_cnt <= '0;
          end
          else if (tx_done)
          begin
            state    <= S_RD_WAIT;
            rx_start <= 1'b1;
          end
        S_GAP:
          if (gap_cnt == bit_cnt_t'(GAP_CYCLES - 2))
          begin
            state    <= S_TX_LO;
            tx_start <= 1'b1;  // low byte goes out right after the gap
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        S_TX_LO: if (tx_done) state <= S_IDLE;
        S_RD_WAIT:
          if (rx_done)
          begin
            rd_req <= 1'b1;
            state  <= S_RD_OFFER;
          end
        S_RD_OFFER:
          if (rd_ack)
          begin
            rd_req <= 1'b0;
            state  <= S_RD_DROP;
          end
        S_RD_DROP: if (!rd_ack) state <= S_IDLE;
        default:   state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      word_q <= go_word;
    if (state == S_RD_WAIT && rx_done)
    begin
      rd_data   <= rx_byte;
      rd_status <= rx_status;
    end
  end

endmodule

`default_nettype wire

/* src/uart_frame_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_frame_rx (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     rx_start,
  input  logic                     rx,
  output logic                     rx_done,
  output uart_bridge_pkg::byte_t   rx_byte,
  output uart_bridge_pkg::status_t rx_status
);

  import uart_bridge_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_WAIT, S_RECV} state_t;

  state_t     state;
  logic       rx_meta;
  logic       rx_sync;
  logic       rx_prev;
  bit_cnt_t   cnt;       // timeout window in S_WAIT, bit time in S_RECV
  logic [3:0] bit_idx;
  byte_t      data_q;
  logic       par_q;
  logic       start_edge;
  logic       timed_out;
  logic       mid_bit;
  logic       last_bit;

  assign start_edge = (state == S_WAIT) && rx_prev && !rx_sync;
  assign timed_out  = (state == S_WAIT) && !start_edge &&
                      (cnt == bit_cnt_t'(TIMEOUT_CYCLES - 1));
  assign mid_bit    = (state == S_RECV) && (cnt == bit_cnt_t'(BIT_CYCLES / 2 - 1));
  assign last_bit   = mid_bit && (bit_idx == 4'(FRAME_BITS - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= S_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      rx_done <= 1'b0;
    end
    else
    begin
      rx_done <= timed_out || last_bit;
      case (state)
        S_IDLE:
          if (rx_start)
          begin
            state <= S_WAIT;
            cnt   <= '0;
          end
        S_WAIT:
          if (start_edge)
          begin
            state   <= S_RECV;
            cnt     <= '0;
            bit_idx <= '0;
          end
          else if (timed_out)
            state <= S_IDLE;
          else
            cnt <= cnt + 1'b1;
        S_RECV:
          if (last_bit)
            state <= S_IDLE;  // done at the middle of the stop bit
          else if (cnt == bit_cnt_t'(BIT_CYCLES - 1))
          begin
            cnt     <= '0;
            bit_idx <= bit_idx + 4'd1;
          end
          else
            cnt <= cnt + 1'b1;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (mid_bit && bit_idx == 4'(FRAME_BITS - 2))
      par_q <= rx_sync;
    else if (mid_bit && bit_idx != 4'd0 && bit_idx < 4'(FRAME_BITS - 2))
      data_q <= {rx_sync, data_q[7:1]};  // lsb arrives first
    if (timed_out)
    begin
      rx_byte   <= '0;
      rx_status <= STATUS_TIMEOUT;
    end
    else if (last_bit)
    begin
      rx_byte   <= data_q;
      rx_status <= (par_q == ~^data_q) ? STATUS_OK : STATUS_PARITY_ERR;
    end
  end

endmodule

`default_nettype wire

/* src/uart_frame_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_frame_tx (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   tx_start,
  input  uart_bridge_pkg::byte_t tx_byte,
  output logic                   tx_done,
  output logic                   tx
);

  import uart_bridge_pkg::*;

  logic       busy;
  bit_cnt_t   bit_cnt;   // cycles into the current bit
  logic [3:0] bit_idx;   // 0 start, 1..8 data, 9 parity, 10 stop
  logic [9:0] shreg;     // bits still to send, stop on top
  logic       load;
  logic       bit_end;

  assign load    = tx_start && !busy;
  assign bit_end = busy && (bit_cnt == bit_cnt_t'(BIT_CYCLES - 1));
  assign tx_done = bit_end && (bit_idx == 4'(FRAME_BITS - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end
    else if (load)
    begin
      busy    <= 1'b1;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b0;  // start bit
    end
    else if (bit_end)
    begin
      bit_cnt <= '0;
      if (tx_done)
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        bit_idx <= bit_idx + 4'd1;
        tx      <= shreg[0];
      end
    end
    else if (busy)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // odd parity: data plus parity bit hold an odd number of ones
  always_ff @(posedge clk)
  begin
    if (load)
      shreg <= {1'b1, ~^tx_byte, tx_byte};
    else if (bit_end)
      shreg <= {1'b1, shreg[9:1]};
  end

endmodule

`default_nettype wire

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD  = 10;  // 20 ns clock
  localparam int RESET_CYCLES = 5;

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* test/tb_uart_cmd_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_uart_cmd_bridge;

  import uart_bridge_pkg::*;

  localparam int NUM_DEVICES = 3;
  localparam int SILENT_CHAN = 3;      // nothing answers here
  localparam int MAX_CYCLES  = 60000;  // ~40 commands below 1000 cycles each, plus margin

  logic                    clk;
  logic                    rst_n;
  logic                    cmd_req;
  logic                    cmd_ack;
  chan_t                   cmd_chan;
  cmd_t                    cmd_word;
  logic                    rsp_req;
  logic                    rsp_ack;
  chan_t                   rsp_chan;
  byte_t                   rsp_data;
  status_t                 rsp_status;
  wire [NUM_CHANNELS-1:0]  tx_lines;
  wire [NUM_CHANNELS-1:0]  rx_lines;
  int                      bad_frames [NUM_DEVICES];

  byte_t      ref_mem [NUM_CHANNELS][128];
  logic [9:0] exp_q [NUM_CHANNELS][$];   // {status, data} per pending read
  integer     seed = 57344;
  string      test_name = "none";
  int         errors = 0;
  int         checks = 0;
  int         tests = 0;
  int         errors_at_start;
  int         checks_at_start;
  int         reads_issued = 0;
  int         rsp_count = 0;
  int         ack_delay = 0;
  int         cycles = 0;

  tb_clock_gen clk_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_cmd_bridge uart_cmd_bridge_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_req    (cmd_req),
    .cmd_ack    (cmd_ack),
    .cmd_chan   (cmd_chan),
    .cmd_word   (cmd_word),
    .rsp_req    (rsp_req),
    .rsp_ack    (rsp_ack),
    .rsp_chan   (rsp_chan),
    .rsp_data   (rsp_data),
    .rsp_status (rsp_status),
    .tx         (tx_lines),
    .rx         (rx_lines)
  );

  for (genvar i = 0; i < NUM_DEVICES; i++)
  begin : g_dev
    uart_device_model dev_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .rx         (tx_lines[i]),
      .tx         (rx_lines[i]),
      .bad_frames (bad_frames[i])
    );
  end

  assign rx_lines[SILENT_CHAN] = 1'b1;

  // host command port, DUT responds
  cmd_ack_rise: assert property (@(posedge clk) disable iff (!rst_n) $rose(cmd_ack) |-> cmd_req)
  else
  begin
    $display("handshake error: cmd_ack rose without cmd_req");
    errors++;
  end
  cmd_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                 cmd_req && cmd_ack |=> cmd_ack)
  else
  begin
    $display("handshake error: cmd_ack dropped while cmd_req was high");
    errors++;
  end
  cmd_ack_fall: assert property (@(posedge clk) disable iff (!rst_n) $fell(cmd_ack) |-> !cmd_req)
  else
  begin
    $display("handshake error: cmd_ack fell with cmd_req high");
    errors++;
  end

  // host response port, DUT requests
  rsp_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                 rsp_req && !rsp_ack |=> rsp_req)
  else
  begin
    $display("handshake error: rsp_req dropped before rsp_ack");
    errors++;
  end
  rsp_req_rise: assert property (@(posedge clk) disable iff (!rst_n) $rose(rsp_req) |-> !rsp_ack)
  else
  begin
    $display("handshake error: rsp_req rose while rsp_ack was high");
    errors++;
  end
  rsp_data_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                  (rsp_req || rsp_ack) |=>
                                  $stable({rsp_chan, rsp_data, rsp_status}))
  else
  begin
    $display("handshake error: response changed during handshake");
    errors++;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("run stopped after %0d cycles in %s, the DUT stopped making progress",
               cycles, test_name);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp)
    else
    begin
      $display("CHECK FAILED %s: %s expected %0h actual %0h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name       = name;
    errors_at_start = errors;
    checks_at_start = checks;
  endtask

  task automatic end_test();
    tests++;
    $display("%-12s %0d checks, %0d errors", test_name,
             checks - checks_at_start, errors - errors_at_start);
  endtask

  task automatic send_cmd(input chan_t ch, input cmd_t word);
    @(posedge clk);
    #1;
    cmd_chan = ch;
    cmd_word = word;
    cmd_req  = 1'b1;
    do @(posedge clk); while (cmd_ack !== 1'b1);
    #1 cmd_req = 1'b0;
    do @(posedge clk); while (cmd_ack !== 1'b0);
  endtask

  task automatic write_reg(input chan_t ch, input logic [6:0] addr, input byte_t data);
    if (ch != SILENT_CHAN)
      ref_mem[ch][addr] = data;
    send_cmd(ch, {1'b1, addr, data});
  endtask

  task automatic read_reg(input chan_t ch, input logic [6:0] addr);
    if (ch == SILENT_CHAN)
      exp_q[ch].push_back({STATUS_TIMEOUT, 8'h00});
    else if (addr == 7'h7F)
      exp_q[ch].push_back({STATUS_PARITY_ERR, 8'hA5});
    else
      exp_q[ch].push_back({STATUS_OK, ref_mem[ch][addr]});
    reads_issued++;
    send_cmd(ch, {1'b0, addr, 8'h00});
  endtask

  task automatic wait_drain();
    while (rsp_count < reads_issued)
      @(posedge clk);
  endtask

  // per channel order is fixed, across channels it is not
  task automatic match_response(input chan_t ch, input byte_t data, input status_t status);
    logic [9:0] exp;
    rsp_count++;
    if (exp_q[ch].size() == 0)
    begin
      $display("unexpected response on channel %0d in %s, no read was pending", ch, test_name);
      errors++;
    end
    else
    begin
      exp = exp_q[ch].pop_front();
      check_value($sformatf("ch%0d data", ch), exp[7:0], data);
      check_value($sformatf("ch%0d status", ch), exp[9:8], status);
    end
  endtask

  initial
  begin
    chan_t   got_chan;
    byte_t   got_data;
    status_t got_status;
    rsp_ack = 1'b0;
    forever
    begin
      do @(posedge clk); while (rsp_req !== 1'b1);
      got_chan   = rsp_chan;
      got_data   = rsp_data;
      got_status = rsp_status;
      repeat (ack_delay) @(posedge clk);  // host back-pressure
      #1 rsp_ack = 1'b1;
      do @(posedge clk); while (rsp_req !== 1'b0);
      #1 rsp_ack = 1'b0;
      match_response(got_chan, got_data, got_status);
    end
  end

  initial
  begin
    logic [6:0] addr;
    byte_t      data;
    logic [6:0] wr_addr [$];
    chan_t      wr_chan [$];
    cmd_req  = 1'b0;
    cmd_chan = '0;
    cmd_word = '0;
    foreach (ref_mem[c, a])
      ref_mem[c][a] = '0;

    begin_test("reset");
    wait (rst_n === 1'b1);
    @(posedge clk);
    check_value("cmd_ack", 0, cmd_ack);
    check_value("rsp_req", 0, rsp_req);
    check_value("tx lines", {NUM_CHANNELS{1'b1}}, tx_lines);
    end_test();

    begin_test("write_read");
    for (int n = 0; n < 3; n++)
    begin
      for (int c = 0; c < NUM_DEVICES; c++)
      begin
        addr = 7'($unsigned($random(seed)) % 127);  // 7F is kept for the parity test
        data = 8'($random(seed));
        write_reg(chan_t'(c), addr, data);
        wr_addr.push_back(addr);
        wr_chan.push_back(chan_t'(c));
      end
    end
    foreach (wr_addr[k])
      read_reg(wr_chan[k], wr_addr[k]);
    wait_drain();
    end_test();

    begin_test("concurrent");
    read_reg(0, wr_addr[0]);
    read_reg(1, wr_addr[1]);
    read_reg(2, wr_addr[2]);
    wait_drain();
    end_test();

    begin_test("backpressure");
    ack_delay = 40;
    addr = 7'($unsigned($random(seed)) % 127);
    write_reg(1, addr, 8'($random(seed)));
    read_reg(1, addr);
    write_reg(1, addr, 8'($random(seed)));  // waits for the first read to drain
    read_reg(1, addr);
    read_reg(0, wr_addr[3]);
    read_reg(2, wr_addr[5]);
    wait_drain();
    repeat (FRAME_BITS * BIT_CYCLES) @(posedge clk);  // room for a repeated response
    ack_delay = 0;
    check_value("response count", reads_issued, rsp_count);
    end_test();

    begin_test("parity_err");
    read_reg(2, 7'h7F);
    wait_drain();
    end_test();

    begin_test("timeout");
    read_reg(SILENT_CHAN, 7'h10);
    write_reg(2, 7'h22, 8'($random(seed)));
    read_reg(2, 7'h22);
    read_reg(0, wr_addr[6]);
    wait_drain();
    end_test();

    begin_test("dev_frames");
    repeat (2 * FRAME_BITS * BIT_CYCLES) @(posedge clk);
    for (int i = 0; i < NUM_DEVICES; i++)
      check_value($sformatf("malformed frames dev%0d", i), 0, bad_frames[i]);
    end_test();

    $display("totals: %0d tests, %0d checks, %0d errors, %0d reads, %0d responses",
             tests, checks, errors, reads_issued, rsp_count);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* test/uart_device_model.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_device_model (
  input  logic clk,
  input  logic rst_n,
  input  logic rx,
  output logic tx,
  output int   bad_frames
);

  import uart_bridge_pkg::*;

  localparam int REPLY_GAP_BITS = 3;

  byte_t regs [128];

  // returns at the middle of the stop bit
  task automatic get_frame(output byte_t data, output logic good);
    logic par;
    logic stp;
    while (rx !== 1'b0)
      @(posedge clk);
    repeat (BIT_CYCLES / 2) @(posedge clk);
    for (int i = 0; i < 8; i++)
    begin
      repeat (BIT_CYCLES) @(posedge clk);
      data[i] = rx;
    end
    repeat (BIT_CYCLES) @(posedge clk);
    par = rx;
    repeat (BIT_CYCLES) @(posedge clk);
    stp = rx;
    good = (^{data, par} == 1'b1) && (stp == 1'b1);  // odd count of ones
  endtask

  task automatic put_frame(input byte_t data, input logic flip_par);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ flip_par, data, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      tx <= bits[i];
      repeat (BIT_CYCLES) @(posedge clk);
    end
  endtask

  initial
  begin
    byte_t hi;
    byte_t lo;
    logic  good;
    tx         = 1'b1;
    bad_frames = 0;
    foreach (regs[a])
      regs[a] = '0;
    wait (rst_n === 1'b1);
    forever
    begin
      get_frame(hi, good);
      if (!good)
        bad_frames++;
      else if (hi[7])
      begin
        get_frame(lo, good);
        if (!good)
          bad_frames++;
        else
          regs[hi[6:0]] = lo;
      end
      else
      begin
        // let the stop bit finish, then idle a little before answering
        repeat (BIT_CYCLES / 2 + REPLY_GAP_BITS * BIT_CYCLES) @(posedge clk);
        if (hi[6:0] == 7'h7F)
          put_frame(8'hA5, 1'b1);  // deliberately broken parity
        else
          put_frame(regs[hi[6:0]], 1'b0);
      end
    end
  end

endmodule

`default_nettype wire
